// ==== rtl/slc3Pkg.sv ====
// Shared word, index, opcode and mux-select types for the LC-3 subset core, imported by all RTL
package slc3Pkg;

	// ----------------------------------------
	// Sizes
	// ----------------------------------------
	localparam int numRegs = 8;                         // R0..R7, R7 is the link register

	typedef logic [15:0] word_t;                        // Data and address word
	typedef logic [$clog2(numRegs)-1:0] regIdx_t;       // Register file index
	typedef logic [11:0] led_t;                         // PAUSE display value, IR[11:0]

	// ----------------------------------------
	// Opcodes in IR[15:12]
	// ----------------------------------------
	typedef enum logic [3:0]
	{
		opBr    = 4'b0000,                              // Conditional branch on NZP
		opAdd   = 4'b0001,                              // Register or imm5 form
		opJsr   = 4'b0100,                              // PC relative subroutine call
		opAnd   = 4'b0101,                              // Register or imm5 form
		opLdr   = 4'b0110,                              // Base plus offset6 load
		opStr   = 4'b0111,                              // Base plus offset6 store
		opNot   = 4'b1001,
		opJmp   = 4'b1100,                              // Also RET through R7
		opPause = 4'b1101                               // Show IR[11:0], wait for operator
	} opcode_t;

	// ----------------------------------------
	// Datapath select encodings
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		aluAdd   = 2'b00,
		aluAnd   = 2'b01,
		aluNot   = 2'b10,
		aluPassA = 2'b11                                // SR1 straight onto the bus
	} aluFn_t;

	typedef enum logic [1:0]
	{
		pcInc   = 2'b00,                                // PC + 1
		pcBus   = 2'b01,                                // JMP target from bus
		pcAdder = 2'b10                                 // Branch and JSR target
	} pcSel_t;

	typedef enum logic [1:0]
	{
		addr2Zero  = 2'b00,
		addr2Off6  = 2'b01,                             // IR[5:0] sign extended
		addr2Off9  = 2'b10,                             // IR[8:0] sign extended
		addr2Off11 = 2'b11                              // IR[10:0] sign extended
	} addr2Sel_t;

endpackage

// ==== rtl/ctrlIf.sv ====
// Control word from the sequencer to the datapath; controlUnit uses modport ctrl, datapath dp
interface ctrlIf;
	import slc3Pkg::*;

	// Register loads
	logic ldMar;
	logic ldMdr;
	logic ldIr;
	logic ldBen;
	logic ldCc;
	logic ldReg;
	logic ldPc;
	logic ldLed;
	// Bus drivers, at most one high
	logic gatePc;
	logic gateMdr;
	logic gateAlu;
	logic gateMarmux;
	// Mux selects
	pcSel_t pcMux;
	logic drMux;                                        // 0 IR[11:9], 1 R7
	logic sr1Mux;                                       // 0 IR[11:9], 1 IR[8:6]
	logic sr2Mux;                                       // 0 register, 1 imm5
	logic addr1Mux;                                     // 0 PC, 1 base register
	addr2Sel_t addr2Mux;
	aluFn_t aluK;
	logic memOe;                                        // Read strobe, high active here

	modport ctrl (output ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
		gatePc, gateMdr, gateAlu, gateMarmux,
		pcMux, drMux, sr1Mux, sr2Mux, addr1Mux, addr2Mux, aluK, memOe);
	modport dp (input ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
		gatePc, gateMdr, gateAlu, gateMarmux,
		pcMux, drMux, sr1Mux, sr2Mux, addr1Mux, addr2Mux, aluK, memOe);

endinterface

// ==== rtl/controlUnit.sv ====
// Instruction sequencer and decoder FSM; drives every load, gate, select and memory strobe
module controlUnit
(
	input logic Clk,
	input logic rstN,
	input logic run,                                    // Start from halted, level sensitive
	input logic cont,                                   // Operator continue after PAUSE
	input slc3Pkg::opcode_t opcode,
	input logic ir5,                                    // Immediate flag for ADD and AND
	input logic ben,                                    // Branch enable latched at decode
	ctrlIf.ctrl ctrl,
	output logic memWeN
);
	import slc3Pkg::*;

	typedef enum logic [4:0]
	{
		halted,
		pauseIr1,                                       // Wait for cont press
		pauseIr2,                                       // Wait for cont release
		s18,                                            // MAR <- PC, PC++
		s33a,                                           // MDR <- M[MAR], first cycle
		s33b,                                           // Second read cycle, MDR loads
		s35,                                            // IR <- MDR
		s32,                                            // Decode, BEN latched
		s01,                                            // ADD
		s05,                                            // AND
		s09,                                            // NOT
		s06,                                            // LDR address
		s25a,                                           // LDR read
		s25b,
		s27,                                            // LDR writeback
		s07,                                            // STR address
		s23,                                            // STR MDR <- SR
		s16a,                                           // STR write
		s16b,
		s04,                                            // JSR R7 <- PC
		s21,                                            // JSR PC <- PC + off11
		s12,                                            // JMP PC <- BaseR
		s00,                                            // BR test
		s22                                             // BR PC <- PC + off9
	} state_t;

	state_t state;
	state_t stateNext;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			state <= halted;
		else
			state <= stateNext;
	end

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb
	begin
		stateNext = state;                              // Hold by default
		case (state)
			halted:
				if (run)
					stateNext = s18;
			pauseIr1:
				if (cont)
					stateNext = pauseIr2;
			pauseIr2:
				if (!cont)
					stateNext = s18;                    // Fetch only after release
			s18:  stateNext = s33a;
			s33a: stateNext = s33b;
			s33b: stateNext = s35;
			s35:  stateNext = s32;
			s32:
				case (opcode)
					opAdd:   stateNext = s01;
					opAnd:   stateNext = s05;
					opNot:   stateNext = s09;
					opBr:    stateNext = s00;
					opJmp:   stateNext = s12;
					opJsr:   stateNext = s04;
					opLdr:   stateNext = s06;
					opStr:   stateNext = s07;
					opPause: stateNext = pauseIr1;
					default: stateNext = halted;        // Unsupported opcode stops the core
				endcase
			s06:  stateNext = s25a;
			s25a: stateNext = s25b;
			s25b: stateNext = s27;
			s07:  stateNext = s23;
			s23:  stateNext = s16a;
			s16a: stateNext = s16b;
			s04:  stateNext = s21;
			s00:  stateNext = ben ? s22 : s18;          // Taken costs one more cycle
			s01, s05, s09, s27, s16b, s21, s12, s22:
				stateNext = s18;
			default:
				stateNext = halted;
		endcase
	end

	// ----------------------------------------
	// Control word decode
	// ----------------------------------------
	always_comb
	begin
		ctrl.ldMar = 1'b0;
		ctrl.ldMdr = 1'b0;
		ctrl.ldIr = 1'b0;
		ctrl.ldBen = 1'b0;
		ctrl.ldCc = 1'b0;
		ctrl.ldReg = 1'b0;
		ctrl.ldPc = 1'b0;
		ctrl.ldLed = 1'b0;
		ctrl.gatePc = 1'b0;
		ctrl.gateMdr = 1'b0;
		ctrl.gateAlu = 1'b0;
		ctrl.gateMarmux = 1'b0;
		ctrl.pcMux = pcInc;
		ctrl.drMux = 1'b0;
		ctrl.sr1Mux = 1'b0;
		ctrl.sr2Mux = 1'b0;
		ctrl.addr1Mux = 1'b0;
		ctrl.addr2Mux = addr2Zero;
		ctrl.aluK = aluAdd;
		ctrl.memOe = 1'b0;
		memWeN = 1'b1;                                  // Pin is low active

		case (state)
			s18:
			begin
				ctrl.gatePc = 1'b1;                     // Old PC into MAR
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;                       // pcInc
			end
			s33a, s25a:
				ctrl.memOe = 1'b1;                      // SRAM settling cycle
			s33b, s25b:
			begin
				ctrl.memOe = 1'b1;
				ctrl.ldMdr = 1'b1;                      // Capture read data
			end
			s35:
			begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			s32:
				ctrl.ldBen = 1'b1;
			pauseIr1, pauseIr2:
				ctrl.ldLed = 1'b1;                      // Show IR[11:0]
			s01, s05, s09:
			begin
				ctrl.sr2Mux = ir5;                      // imm5 when IR[5] set
				ctrl.sr1Mux = 1'b1;                     // IR[8:6]
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				if (state == s05)
					ctrl.aluK = aluAnd;
				else if (state == s09)
					ctrl.aluK = aluNot;
			end
			s06, s07:
			begin
				ctrl.sr1Mux = 1'b1;                     // BaseR in IR[8:6]
				ctrl.addr1Mux = 1'b1;
				ctrl.addr2Mux = addr2Off6;
				ctrl.gateMarmux = 1'b1;
				ctrl.ldMar = 1'b1;
			end
			s27:
			begin
				ctrl.gateMdr = 1'b1;                    // Loaded word to DR
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			s23:
			begin
				ctrl.aluK = aluPassA;                   // SR in IR[11:9] through ALU
				ctrl.gateAlu = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			s16a, s16b:
				memWeN = 1'b0;                          // MAR and MDR held stable
			s04:
			begin
				ctrl.gatePc = 1'b1;                     // Return address to R7
				ctrl.drMux = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;                       // Every register write sets CC
			end
			s21:
			begin
				ctrl.addr2Mux = addr2Off11;
				ctrl.pcMux = pcAdder;
				ctrl.ldPc = 1'b1;
			end
			s12:
			begin
				ctrl.sr1Mux = 1'b1;
				ctrl.aluK = aluPassA;
				ctrl.gateAlu = 1'b1;
				ctrl.pcMux = pcBus;
				ctrl.ldPc = 1'b1;
			end
			s22:
			begin
				ctrl.addr2Mux = addr2Off9;
				ctrl.pcMux = pcAdder;
				ctrl.ldPc = 1'b1;
			end
			default: ;                                  // halted, s00 idle
		endcase
	end

endmodule

// ==== rtl/regFile.sv ====
// Eight-word general register file; two asynchronous read ports and one clocked write port
module regFile
(
	input logic Clk,
	input logic rstN,
	input logic we,
	input slc3Pkg::regIdx_t wrIdx,
	input slc3Pkg::regIdx_t rdIdxA,
	input slc3Pkg::regIdx_t rdIdxB,
	input slc3Pkg::word_t wrData,
	output slc3Pkg::word_t rdDataA,
	output slc3Pkg::word_t rdDataB
);
	import slc3Pkg::*;

	word_t regs [numRegs];                              // R0..R7

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;                          // Program sees zeroed registers
		end
		else if (we)
		begin
			regs[wrIdx] <= wrData;
		end
	end

	// Reads see the old value during a write cycle
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

endmodule

// ==== rtl/datapath.sv ====
// Processor datapath with PC, MAR, MDR, IR, CC, BEN, ALU, address adder and the shared bus
module datapath
(
	input logic Clk,
	input logic rstN,
	input slc3Pkg::word_t memRdData,
	ctrlIf.dp ctrl,
	output slc3Pkg::word_t memAddr,
	output slc3Pkg::word_t memWrData,
	output slc3Pkg::opcode_t opcode,
	output logic ir5,
	output logic ben,
	output slc3Pkg::led_t led
);
	import slc3Pkg::*;

	word_t pc;
	word_t mar;
	word_t mdr;
	word_t ir;
	logic [2:0] nzp;                                    // Condition codes N, Z, P
	word_t bus;
	word_t aluOut;
	word_t aluB;
	word_t addr1;
	word_t addr2;
	word_t adderOut;
	word_t pcNext;
	word_t sr1Data;
	word_t sr2Data;
	regIdx_t wrIdx;
	regIdx_t sr1Idx;

	// ----------------------------------------
	// Register file and operand selection
	// ----------------------------------------
	assign wrIdx = ctrl.drMux ? 3'd7 : ir[11:9];        // R7 for JSR link
	assign sr1Idx = ctrl.sr1Mux ? ir[8:6] : ir[11:9];

	regFile i_regFile
	(
		.Clk(Clk),
		.rstN(rstN),
		.we(ctrl.ldReg),
		.wrIdx(wrIdx),
		.rdIdxA(sr1Idx),
		.rdIdxB(ir[2:0]),
		.wrData(bus),
		.rdDataA(sr1Data),
		.rdDataB(sr2Data)
	);

	assign aluB = ctrl.sr2Mux ? {{11{ir[4]}}, ir[4:0]} : sr2Data; // imm5 sign extended

	always_comb
	begin
		case (ctrl.aluK)
			aluAdd:  aluOut = sr1Data + aluB;
			aluAnd:  aluOut = sr1Data & aluB;
			aluNot:  aluOut = ~sr1Data;
			default: aluOut = sr1Data;                  // Pass A
		endcase
	end

	// ----------------------------------------
	// Address adder and PC source
	// ----------------------------------------
	always_comb
	begin
		case (ctrl.addr2Mux)
			addr2Off6:  addr2 = {{10{ir[5]}}, ir[5:0]};
			addr2Off9:  addr2 = {{7{ir[8]}}, ir[8:0]};
			addr2Off11: addr2 = {{5{ir[10]}}, ir[10:0]};
			default:    addr2 = '0;
		endcase
	end

	assign addr1 = ctrl.addr1Mux ? sr1Data : pc;        // Base register or PC
	assign adderOut = addr1 + addr2;

	always_comb
	begin
		case (ctrl.pcMux)
			pcBus:   pcNext = bus;
			pcAdder: pcNext = adderOut;
			default: pcNext = pc + 16'd1;
		endcase
	end

	// Single gate active, idle bus reads zero
	always_comb
	begin
		bus = '0;
		if (ctrl.gatePc)
			bus = pc;
		else if (ctrl.gateMdr)
			bus = mdr;
		else if (ctrl.gateAlu)
			bus = aluOut;
		else if (ctrl.gateMarmux)
			bus = adderOut;
	end

	// ----------------------------------------
	// Architectural registers
	// ----------------------------------------
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			mar <= '0;
			mdr <= '0;
			ir <= '0;
			nzp <= '0;
			ben <= 1'b0;
			led <= '0;
		end
		else
		begin
			if (ctrl.ldPc)
				pc <= pcNext;
			if (ctrl.ldMar)
				mar <= bus;
			if (ctrl.ldMdr)
				mdr <= ctrl.memOe ? memRdData : bus;    // SRAM read or store data
			if (ctrl.ldIr)
				ir <= bus;
			if (ctrl.ldCc)
				nzp <= {bus[15], bus == '0, !bus[15] && bus != '0};
			if (ctrl.ldBen)
				ben <= |(ir[11:9] & nzp);               // Branch mask against CC
			if (ctrl.ldLed)
				led <= ir[11:0];
		end
	end

	assign memAddr = mar;
	assign memWrData = mdr;
	assign opcode = opcode_t'(ir[15:12]);
	assign ir5 = ir[5];

endmodule

// ==== rtl/slc3Top.sv ====
// Top level of the LC-3 subset core; connects sequencer and datapath to the external SRAM pins
module slc3Top
(
	input logic Clk,
	input logic rstN,
	input logic run,                                    // Start or restart from halted
	input logic cont,                                   // Continue after PAUSE
	input slc3Pkg::word_t memRdData,
	output slc3Pkg::word_t memAddr,
	output slc3Pkg::word_t memWrData,
	output logic memOeN,
	output logic memWeN,
	output slc3Pkg::led_t led
);
	import slc3Pkg::*;

	ctrlIf ctrlBus ();                                  // Control word bundle

	opcode_t opcode;
	logic ir5;
	logic ben;

	controlUnit i_controlUnit
	(
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.cont(cont),
		.opcode(opcode),
		.ir5(ir5),
		.ben(ben),
		.ctrl(ctrlBus),
		.memWeN(memWeN)
	);

	datapath i_datapath
	(
		.Clk(Clk),
		.rstN(rstN),
		.memRdData(memRdData),
		.ctrl(ctrlBus),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.opcode(opcode),
		.ir5(ir5),
		.ben(ben),
		.led(led)
	);

	// SRAM output enable pin is low active
	assign memOeN = ~ctrlBus.memOe;

endmodule

// ==== tb/slc3Tb.sv ====
// Testbench for the LC-3 subset core: SRAM model, program image, ISA reference model and checks
module slc3Tb;
	timeunit 1ns;
	timeprecision 100ps;
	import slc3Pkg::*;

	typedef enum {evStore, evPause, evHalt} event_t;

	localparam int holdCycles = 15;                     // cont held low after a PAUSE
	localparam int idleLimit = 20;                      // Quiet read strobe means halted
	localparam int numHalts = 2;                        // Unknown opcodes in the program
	localparam int progInstr = 50;                      // Instructions executed, with margin
	localparam int limitNs = (progInstr * 10 + 2 * (holdCycles + 10)
		+ numHalts * (idleLimit + 10) + 10) * 4;

	logic Clk = 1'b0;
	logic rstN;
	logic run;
	logic cont;
	word_t memRdData;
	word_t memAddr;
	word_t memWrData;
	logic memOeN;
	logic memWeN;
	led_t led;

	word_t mem [256];                                   // SRAM seen by the DUT
	word_t refMem [256];                                // Model's own image
	word_t refReg [8];
	word_t refPc;
	logic [2:0] refNzp;
	logic prevWeN;
	led_t prevLed;

	slc3Top i_slc3Top
	(
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.cont(cont),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memOeN(memOeN),
		.memWeN(memWeN),
		.led(led)
	);

	always #2 Clk = ~Clk;                               // 4 ns period

	// ----------------------------------------
	// SRAM model
	// ----------------------------------------
	assign memRdData = memOeN ? 16'h0000 : mem[memAddr[7:0]];

	always @(negedge Clk)
	begin
		if (!memWeN)
			mem[memAddr[7:0]] = memWrData;               // Mid-cycle, address held stable
	end

	// ----------------------------------------
	// Program image helpers
	// ----------------------------------------
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t rr(input logic [3:0] op, input int dr, input int sa, input int sb);
		return {op, 3'(dr), 3'(sa), 3'b000, 3'(sb)};
	endfunction

	function automatic word_t ri(input logic [3:0] op, input int dr, input int sa, input int imm);
		return {op, 3'(dr), 3'(sa), 1'b1, 5'(imm)};
	endfunction

	function automatic word_t mo(input logic [3:0] op, input int r, input int b, input int off);
		return {op, 3'(r), 3'(b), 6'(off)};                 // LDR and STR
	endfunction

	function automatic word_t br(input int nzp, input int off);
		return {4'h0, 3'(nzp), 9'(off)};
	endfunction

	task automatic loadProgram();
		logic [31:0] seed;
		seed = 32'h7c749ddd;
		for (int a = 0; a < 256; a++)
		begin
			seed = lcgNext(seed);
			mem[a] = seed[31:16] ^ {8'ha5, 8'(a)};
		end
		mem[0] = mo(4'h6, 6, 0, 3);                     // R6 <- data base
		mem[1] = mo(4'h6, 5, 0, 4);                     // R5 <- store area
		mem[2] = {4'h4, 1'b1, 11'd2};                   // JSR to 5
		mem[3] = 16'h0080;
		mem[4] = 16'h00a0;
		mem[5] = mo(4'h7, 7, 5, 0);                     // Link value
		mem[6] = mo(4'h6, 1, 6, 0);
		mem[7] = mo(4'h6, 2, 6, 1);
		mem[8] = rr(4'h1, 3, 1, 2);
		mem[9] = mo(4'h7, 3, 5, 1);
		mem[10] = ri(4'h1, 3, 1, -7);
		mem[11] = mo(4'h7, 3, 5, 2);
		mem[12] = rr(4'h5, 3, 1, 2);
		mem[13] = mo(4'h7, 3, 5, 3);
		mem[14] = ri(4'h5, 3, 2, 13);
		mem[15] = mo(4'h7, 3, 5, 4);
		mem[16] = {4'h9, 3'd3, 3'd1, 6'h3f};            // NOT R3, R1
		mem[17] = mo(4'h7, 3, 5, 5);
		mem[18] = mo(4'h6, 4, 6, -1);                   // Negative offsets
		mem[19] = mo(4'h7, 4, 5, -2);
		mem[20] = mo(4'h6, 3, 5, -2);                   // Round trip
		mem[21] = mo(4'h7, 3, 5, 6);
		mem[22] = {4'hd, 12'ha5c};                      // PAUSE
		mem[23] = ri(4'h1, 3, 1, 0);                    // CC from random R1
		mem[24] = br(3, 2);                             // BRzp
		mem[25] = ri(4'h1, 4, 0, 5);
		mem[26] = br(1, 1);                             // BRp, taken
		mem[27] = ri(4'h1, 4, 0, 9);
		mem[28] = mo(4'h7, 4, 5, 7);                    // Marker shows the path
		mem[29] = br(6, 1);                             // BRnz, not taken
		mem[30] = ri(4'h1, 4, 0, 3);
		mem[31] = mo(4'h7, 4, 5, 8);
		mem[32] = ri(4'h1, 2, 7, 15);                   // R2 <- 37
		mem[33] = ri(4'h1, 2, 2, 15);
		mem[34] = ri(4'h1, 2, 2, 4);
		mem[35] = {4'hc, 3'd0, 3'd2, 6'd0};             // JMP R2
		mem[36] = mo(4'h7, 0, 5, 9);                    // Skipped
		mem[37] = mo(4'h7, 2, 5, 10);
		mem[38] = 16'hf025;                             // Unsupported, halts
		mem[39] = rr(4'h1, 3, 3, 1);
		mem[40] = mo(4'h7, 3, 5, 11);
		mem[41] = {4'hd, 12'h3c1};
		mem[42] = mo(4'h7, 1, 5, 12);
		mem[43] = 16'h8000;                             // Final halt
		refMem = mem;
	endtask

	// ----------------------------------------
	// Instruction-level reference model
	// ----------------------------------------
	function automatic logic [2:0] ccOf(input word_t v);
		return {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
	endfunction

	function automatic event_t refStep(output word_t evAddr, output word_t evData);
		word_t ir;
		word_t a;
		word_t b;
		word_t v;
		evAddr = '0;
		evData = '0;
		forever
		begin
			ir = refMem[refPc[7:0]];
			refPc = refPc + 16'd1;
			a = refReg[ir[8:6]];
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : refReg[ir[2:0]];
			case (ir[15:12])
				4'h1, 4'h5, 4'h9, 4'h6:
				begin
					if (ir[15:12] == 4'h1)
						v = a + b;
					else if (ir[15:12] == 4'h5)
						v = a & b;
					else if (ir[15:12] == 4'h9)
						v = ~a;
					else
						v = refMem[8'(a + {{10{ir[5]}}, ir[5:0]})];
					refReg[ir[11:9]] = v;
					refNzp = ccOf(v);
				end
				4'h7:
				begin
					evAddr = a + {{10{ir[5]}}, ir[5:0]};
					evData = refReg[ir[11:9]];
					refMem[evAddr[7:0]] = evData;
					return evStore;
				end
				4'h0:
					if (|(ir[11:9] & refNzp))
						refPc = refPc + {{7{ir[8]}}, ir[8:0]};
				4'hc:
					refPc = a;
				4'h4:
				begin
					refReg[7] = refPc;                  // Link write also sets CC
					refNzp = ccOf(refPc);
					refPc = refPc + {{5{ir[10]}}, ir[10:0]};
				end
				4'hd:
				begin
					evData = {4'h0, ir[11:0]};
					return evPause;
				end
				default:
					return evHalt;
			endcase
		end
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkWord(input string name, input word_t exp, input word_t got);
		if (exp !== got)
		begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic checkLed(input string name, input led_t exp, input led_t got);
		if (exp !== got)
		begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic stopRun(input string why);
		$display("At %0t ns: %s", $time, why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	// Samples at the falling edge, where all DUT outputs are settled
	task automatic waitEvent(output event_t kind);
		int idle;
		idle = 0;
		forever
		begin
			@(negedge Clk);
			idle = memOeN ? idle + 1 : 0;
			if (prevWeN && !memWeN)
			begin
				kind = evStore;
				prevWeN = memWeN;
				return;
			end
			prevWeN = memWeN;
			if (led !== prevLed)
			begin
				kind = evPause;
				prevLed = led;
				return;
			end
			if (idle >= idleLimit)
			begin
				kind = evHalt;
				return;
			end
		end
	endtask

	// ----------------------------------------
	// Stimulus and comparison
	// ----------------------------------------
	initial
	begin
		event_t expKind;
		event_t gotKind;
		word_t expAddr;
		word_t expData;
		int halts;
		rstN = 1'b0;
		run = 1'b0;
		cont = 1'b0;
		halts = 0;
		loadProgram();
		refReg = '{default: 16'h0000};
		refPc = 16'h0000;
		refNzp = 3'b000;
		prevWeN = 1'b1;
		prevLed = '0;
		repeat (2) @(posedge Clk);
		#1 rstN = 1'b1;
		run = 1'b1;
		@(posedge Clk);
		#1 run = 1'b0;
		while (halts < numHalts)
		begin
			expKind = refStep(expAddr, expData);
			waitEvent(gotKind);
			if (gotKind != expKind)
				stopRun($sformatf("processor gave event %s where %s was due",
					gotKind.name(), expKind.name()));
			case (gotKind)
				evStore:
				begin
					checkWord("memAddr", expAddr, memAddr);
					checkWord("memWrData", expData, memWrData);
				end
				evPause:
				begin
					checkLed("led", led_t'(expData), led);
					repeat (holdCycles)
					begin
						@(negedge Clk);
						if (!memWeN || !memOeN)
							stopRun("processor ran on while paused");
					end
					@(posedge Clk);
					#1 cont = 1'b1;                     // Press
					repeat (3) @(posedge Clk);
					#1 cont = 1'b0;                     // Release
				end
				default:
				begin
					halts++;
					if (halts < numHalts)
					begin
						@(posedge Clk);
						#1 run = 1'b1;                  // Restart from current PC
						@(posedge Clk);
						#1 run = 1'b0;
					end
				end
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(limitNs);
		$display("Timeout: the processor did not finish the program");
		$display("ERRORS FOUND");
		$fatal(1);
	end

endmodule

// ==== slc3.f ====
rtl/slc3Pkg.sv
rtl/ctrlIf.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/datapath.sv
rtl/slc3Top.sv
tb/slc3Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slc3 simulation with Verilator; exit status is the test result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall --top-module slc3Tb -f slc3.f -o slc3Sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/slc3Sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0
